/* verilog/core_pkg.sv */
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int mul_steps = 32;
    localparam int mul_cnt_w = $clog2(mul_steps);

    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [11:0] csr_instret_addr = 12'hc02;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]           imm20;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_type_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_sltu, alu_lui, alu_mul, alu_csr, alu_link
    } alu_op_e;

    typedef enum logic [1:0] {br_none, br_beq, br_bne, br_jal} br_e;

    typedef enum logic {csr_cycle, csr_instret} csr_sel_e;

    typedef struct packed {
        logic                  rf_wen;
        logic [reg_addr_w-1:0] wb_addr;
        alu_op_e               alu_op;
        br_e                   br;
        csr_sel_e              csr_sel;
        logic                  use_imm;
        logic                  is_exit;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        ctrl_t           ctrl;
    } id_exe_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        ctrl_t           ctrl;
        logic [xlen-1:0] result;
    } exe_wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] inst;
    } fetch_resp_t;

endpackage

/* verilog/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [core_pkg::xlen-1:0] a,
    input  logic [core_pkg::xlen-1:0] b,
    output logic                      busy,
    output logic                      done,
    output logic [core_pkg::xlen-1:0] product
);

    import core_pkg::*;

    typedef enum logic [1:0] {st_idle, st_run, st_done} state_e;

    state_e               state;
    logic [mul_cnt_w-1:0] step;
    logic [xlen-1:0]      mcand;
    logic [xlen-1:0]      mplier;
    logic [xlen-1:0]      acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        step  <= '0;
                    end
                end
                st_run: begin
                    step <= step + 1'b1;
                    if (step == mul_cnt_w'(mul_steps - 1)) begin
                        state <= st_done;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // only the low word is kept, so the multiplicand may wrap
    always_ff @(posedge clk) begin
        if (start && state == st_idle) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == st_run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign busy    = (state == st_run);
    assign done    = (state == st_done);
    assign product = acc;

endmodule

/* verilog/perf_counters.sv */
`timescale 1ns/1ps

module perf_counters (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        retire,
    input  logic        halt,
    output logic [63:0] cycle,
    output logic [63:0] instret
);

    logic [63:0] instret_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle     <= '0;
            instret_q <= '0;
        end else begin
            if (!halt) begin
                cycle <= cycle + 64'd1;
            end
            if (retire) begin
                instret_q <= instret_q + 64'd1;
            end
        end
    end

    // count a retire in flight so reads in execute see it
    assign instret = instret_q + 64'(retire);

endmodule

/* verilog/writeback_regfile.sv */
`timescale 1ns/1ps

module writeback_regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  core_pkg::exe_wb_t               wb,
    input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [core_pkg::xlen-1:0]       rs1_data,
    output logic [core_pkg::xlen-1:0]       rs2_data,
    output logic                            retire,
    output logic                            exit,
    output logic [core_pkg::xlen-1:0]       gp
);

    import core_pkg::*;

    logic [xlen-1:0] regs [0:(1 << reg_addr_w) - 1];

    // nothing behind the ecall commits once exit is up
    assign retire = wb.valid && !exit;

    always_ff @(posedge clk) begin
        if (retire && wb.ctrl.rf_wen && wb.ctrl.wb_addr != '0) begin
            regs[wb.ctrl.wb_addr] <= wb.result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exit <= 1'b0;
        end else if (retire && wb.ctrl.is_exit) begin
            exit <= 1'b1;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign gp       = regs[3];

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                           id_valid,
    input  logic [core_pkg::xlen-1:0]      id_pc,
    input  core_pkg::instr_t               id_inst,
    input  logic [core_pkg::xlen-1:0]      rs1_data,
    input  logic [core_pkg::xlen-1:0]      rs2_data,
    input  core_pkg::ctrl_t                exe_ctrl,
    input  logic                           exe_valid,
    input  core_pkg::ctrl_t                wb_ctrl,
    input  logic                           wb_valid,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    output core_pkg::id_exe_t              id_exe,
    output logic                           dh_stall
);

    import core_pkg::*;

    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic            known;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            exe_wr;
    logic            wb_wr;
    logic            rs1_hit;
    logic            rs2_hit;

    assign rs1_addr = id_inst.r.rs1;
    assign rs2_addr = id_inst.r.rs2;

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        known    = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (id_inst.r.opcode)
            op_imm: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_addr = id_inst.i.rd;
                ctrl.use_imm = 1'b1;
                imm          = {{20{id_inst.i.imm12[11]}}, id_inst.i.imm12};
                uses_rs1     = 1'b1;
            end
            op_reg: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_addr = id_inst.r.rd;
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                if (id_inst.r.funct7 == 7'b0000001) begin
                    ctrl.alu_op = alu_mul;
                end else if (id_inst.r.funct7 == 7'b0100000) begin
                    ctrl.alu_op = alu_sub;
                end else if (id_inst.r.funct3 == 3'b011) begin
                    ctrl.alu_op = alu_sltu;
                end
            end
            op_lui: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_addr = id_inst.u.rd;
                ctrl.alu_op  = alu_lui;
                imm          = {id_inst.u.imm20, 12'b0};
            end
            op_branch: begin
                ctrl.br  = id_inst.b.funct3[0] ? br_bne : br_beq;
                imm      = {{19{id_inst.b.imm12}}, id_inst.b.imm12, id_inst.b.imm11,
                            id_inst.b.imm10_5, id_inst.b.imm4_1, 1'b0};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            op_jal: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_addr = id_inst.j.rd;
                ctrl.alu_op  = alu_link;
                ctrl.br      = br_jal;
                imm          = {{11{id_inst.j.imm20}}, id_inst.j.imm20, id_inst.j.imm19_12,
                                id_inst.j.imm11, id_inst.j.imm10_1, 1'b0};
            end
            op_system: begin
                // csrrs reads a counter and anything else is ecall
                if (id_inst.i.funct3 == 3'b010) begin
                    ctrl.rf_wen  = 1'b1;
                    ctrl.wb_addr = id_inst.i.rd;
                    ctrl.alu_op  = alu_csr;
                    ctrl.csr_sel = (id_inst.i.imm12 == csr_instret_addr) ? csr_instret
                                                                          : csr_cycle;
                end else begin
                    ctrl.is_exit = 1'b1;
                end
            end
            default: known = 1'b0;
        endcase
        // x0 is never written
        if (ctrl.wb_addr == '0) begin
            ctrl.rf_wen = 1'b0;
        end
    end

    assign exe_wr  = exe_valid && exe_ctrl.rf_wen;
    assign wb_wr   = wb_valid && wb_ctrl.rf_wen;
    assign rs1_hit = uses_rs1 && (rs1_addr != '0) &&
                     ((exe_wr && exe_ctrl.wb_addr == rs1_addr) ||
                      (wb_wr && wb_ctrl.wb_addr == rs1_addr));
    assign rs2_hit = uses_rs2 && (rs2_addr != '0) &&
                     ((exe_wr && exe_ctrl.wb_addr == rs2_addr) ||
                      (wb_wr && wb_ctrl.wb_addr == rs2_addr));
    assign dh_stall = id_valid && (rs1_hit || rs2_hit);

    always_comb begin
        id_exe.valid   = id_valid && known;
        id_exe.pc      = id_pc;
        id_exe.rs1_val = rs1_data;
        id_exe.rs2_val = rs2_data;
        id_exe.imm     = imm;
        id_exe.ctrl    = ctrl;
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_pkg::id_exe_t         id_exe,
    input  logic [63:0]               cycle,
    input  logic [63:0]               instret,
    output core_pkg::exe_wb_t         exe_wb,
    output logic                      redirect,
    output logic [core_pkg::xlen-1:0] redirect_addr,
    output logic                      calc_stall
);

    import core_pkg::*;

    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;
    logic [xlen-1:0] product;
    logic            is_mul;
    logic            mul_start;
    logic            mul_busy;
    logic            mul_done;
    logic            taken;

    assign op_b = id_exe.ctrl.use_imm ? id_exe.imm : id_exe.rs2_val;

    always_comb begin
        case (id_exe.ctrl.alu_op)
            alu_sub:  result = id_exe.rs1_val - op_b;
            alu_sltu: result = xlen'(id_exe.rs1_val < op_b);
            alu_lui:  result = id_exe.imm;
            alu_mul:  result = product;
            alu_csr:  result = (id_exe.ctrl.csr_sel == csr_instret) ? instret[xlen-1:0]
                                                                     : cycle[xlen-1:0];
            alu_link: result = id_exe.pc + xlen'(4);
            default:  result = id_exe.rs1_val + op_b;
        endcase
    end

    always_comb begin
        case (id_exe.ctrl.br)
            br_beq:  taken = (id_exe.rs1_val == id_exe.rs2_val);
            br_bne:  taken = (id_exe.rs1_val != id_exe.rs2_val);
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect      = id_exe.valid && taken;
    assign redirect_addr = id_exe.pc + id_exe.imm;

    // hold execute from issue until the product is ready
    assign is_mul     = id_exe.valid && (id_exe.ctrl.alu_op == alu_mul);
    assign mul_start  = is_mul && !mul_busy && !mul_done;
    assign calc_stall = is_mul && !mul_done;

    mul_unit i_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (mul_start),
        .a      (id_exe.rs1_val),
        .b      (id_exe.rs2_val),
        .busy   (mul_busy),
        .done   (mul_done),
        .product(product)
    );

    always_comb begin
        exe_wb.valid  = id_exe.valid && !calc_stall;
        exe_wb.pc     = id_exe.pc;
        exe_wb.ctrl   = id_exe.ctrl;
        exe_wb.result = result;
    end

endmodule

/* verilog/core.sv */
`timescale 1ns/1ps

module core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::fetch_resp_t    iresp,
    output core_pkg::fetch_req_t     ireq,
    output logic                     fetch_ready,
    output logic                     exit,
    output logic [core_pkg::xlen-1:0] gp
);

    import core_pkg::*;

    logic                  id_valid;
    logic [xlen-1:0]       id_pc;
    instr_t                id_inst;
    id_exe_t               id_exe;
    id_exe_t               exe_q;
    exe_wb_t               exe_wb;
    exe_wb_t               wb_q;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  dh_stall;
    logic                  calc_stall;
    logic                  redirect;
    logic [xlen-1:0]       redirect_addr;
    logic                  retire;
    logic [63:0]           cycle;
    logic [63:0]           instret;
    logic                  exe_stall;
    logic                  id_stall;
    logic                  fetch_accept;

    assign exe_stall = calc_stall;
    assign id_stall  = exe_stall || dh_stall;

    // a taken branch in execute restarts the fetch stream
    assign ireq.valid = redirect;
    assign ireq.addr  = redirect_addr;

    assign fetch_ready  = !id_stall && !redirect && !exit;
    assign fetch_accept = fetch_ready && iresp.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (redirect) begin
            id_valid <= 1'b0;
        end else if (!id_stall) begin
            id_valid <= fetch_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            id_pc   <= iresp.addr;
            id_inst <= iresp.inst;
        end
    end

    // hazard or squash sends a bubble into execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_q <= '0;
        end else if (!exe_stall) begin
            if (dh_stall || redirect) begin
                exe_q.valid <= 1'b0;
            end else begin
                exe_q <= id_exe;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= exe_wb;
        end
    end

    decode_stage i_decode (
        .id_valid (id_valid),
        .id_pc    (id_pc),
        .id_inst  (id_inst),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .exe_ctrl (exe_q.ctrl),
        .exe_valid(exe_q.valid),
        .wb_ctrl  (wb_q.ctrl),
        .wb_valid (wb_q.valid),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .id_exe   (id_exe),
        .dh_stall (dh_stall)
    );

    execute_stage i_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_exe       (exe_q),
        .cycle        (cycle),
        .instret      (instret),
        .exe_wb       (exe_wb),
        .redirect     (redirect),
        .redirect_addr(redirect_addr),
        .calc_stall   (calc_stall)
    );

    perf_counters i_counters (
        .clk    (clk),
        .rst_n  (rst_n),
        .retire (retire),
        .halt   (exit),
        .cycle  (cycle),
        .instret(instret)
    );

    writeback_regfile i_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb      (wb_q),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .retire  (retire),
        .exit    (exit),
        .gp      (gp)
    );

endmodule

/* dv/core_properties.sv */
`timescale 1ns/1ps

module core_properties (
    input logic clk,
    input logic rst_n,
    input logic ireq_valid,
    input logic fetch_ready,
    input logic exit,
    input logic calc_stall
);

    import core_pkg::*;

    int stall_run;
    int fail_count = 0;

    // consecutive cycles of multiplier stall seen so far
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_run <= 0;
        end else if (calc_stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    exit_sticky: assert property (@(posedge clk) disable iff (!rst_n) exit |=> exit)
        else begin
            $error("exit fell without a reset");
            fail_count++;
        end

    // the squash leaves decode and execute empty, so fetch resumes at once
    redirect_then_refetch: assert property (@(posedge clk) disable iff (!rst_n)
        ireq_valid |=> !ireq_valid && (fetch_ready || exit))
        else begin
            $error("redirect did not end in one cycle with fetch reopened");
            fail_count++;
        end

    stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        calc_stall |-> stall_run < mul_steps + 2)
        else begin
            $error("multiplier stall ran too long");
            fail_count++;
        end

endmodule

bind core core_properties i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .ireq_valid (ireq.valid),
    .fetch_ready(fetch_ready),
    .exit       (exit),
    .calc_stall (calc_stall)
);

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    import core_pkg::*;

    localparam int max_cycles = 2000;
    localparam logic [6:0] f7_sub = 7'h20;
    localparam logic [6:0] f7_mul = 7'h01;
    localparam logic [11:0] csr_cycle_addr = 12'hc00;
    localparam logic [11:0] csr_instret_addr_tb = 12'hc02;

    logic            clk;
    logic            rst_n;
    fetch_resp_t     iresp;
    fetch_req_t      ireq;
    logic            fetch_ready;
    logic            exit;
    logic [xlen-1:0] gp;

    logic [xlen-1:0] imem [0:255];
    logic [xlen-1:0] nxt_pc;
    logic            nxt_valid;
    logic [xlen-1:0] exp_targets [$];
    int              wr_ptr;
    int              seed;
    int              cycles = 0;

    core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .iresp      (iresp),
        .ireq       (ireq),
        .fetch_ready(fetch_ready),
        .exit       (exit),
        .gp         (gp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: exit never came within %0d cycles", max_cycles);
            $display("Verification failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_props.fail_count != 0) begin
            $display("a bound assertion on the core pipeline failed");
            $display("Verification failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // instruction memory drives on negedge and samples the core mid-cycle
    always begin
        @(negedge clk);
        iresp.valid = nxt_valid;
        iresp.addr  = nxt_pc;
        iresp.inst  = imem[nxt_pc[9:2]];
        #10;
        if (!rst_n) begin
            nxt_pc    = '0;
            nxt_valid = 1'b0;
        end else begin
            if (ireq.valid) begin
                if (exp_targets.size() == 0) begin
                    $display("unexpected fetch redirect to %h", ireq.addr);
                    $display("Verification failed");
                    $fatal(1);
                end else begin
                    check_value("redirect target", exp_targets.pop_front(), ireq.addr);
                end
                nxt_pc = ireq.addr;
            end else if (iresp.valid && fetch_ready) begin
                nxt_pc = nxt_pc + 32'd4;
            end
            nxt_valid = 1'b1;
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        instr_t w;
        w = '0;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.rd     = rd;
        w.i.opcode = op_imm;
        return w;
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        instr_t w;
        w = '0;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = op_reg;
        return w;
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        instr_t w;
        w = '0;
        w.u.imm20  = imm;
        w.u.rd     = rd;
        w.u.opcode = op_lui;
        return w;
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        instr_t w;
        w = '0;
        w.b.imm12   = off[12];
        w.b.imm10_5 = off[10:5];
        w.b.rs2     = rs2;
        w.b.rs1     = rs1;
        w.b.funct3  = f3;
        w.b.imm4_1  = off[4:1];
        w.b.imm11   = off[11];
        w.b.opcode  = op_branch;
        return w;
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        instr_t w;
        w = '0;
        w.j.imm20    = off[20];
        w.j.imm10_1  = off[10:1];
        w.j.imm11    = off[11];
        w.j.imm19_12 = off[19:12];
        w.j.rd       = rd;
        w.j.opcode   = op_jal;
        return w;
    endfunction

    function automatic logic [31:0] csrr_word(input logic [4:0] rd, input logic [11:0] csr);
        instr_t w;
        w = '0;
        w.i.imm12  = csr;
        w.i.funct3 = 3'b010;
        w.i.rd     = rd;
        w.i.opcode = op_system;
        return w;
    endfunction

    function automatic logic [31:0] ecall_word();
        instr_t w;
        w = '0;
        w.i.opcode = op_system;
        return w;
    endfunction

    // idle fill is a nop tagged with its own word index
    task automatic clear_memory();
        for (int k = 0; k < 256; k++) begin
            imem[k] = addi_word(5'd0, 5'd0, 12'(k));
        end
        wr_ptr = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[wr_ptr] = word;
        wr_ptr++;
    endtask

    task automatic run_program(input string name);
        @(negedge clk);
        rst_n = 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_value({name, " exit in reset"}, 32'd0, exit);
            check_value({name, " redirect in reset"}, 32'd0, ireq.valid);
        end
        rst_n = 1'b1;
        while (exit !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic arith_chain();
        logic [11:0] ia;
        logic [11:0] ib;
        logic [19:0] iu;
        logic [31:0] r5;
        logic [31:0] r6;
        logic [31:0] r7;
        logic [31:0] r8;
        logic [31:0] r9;
        logic [31:0] r10;
        ia  = 12'($random(seed));
        ib  = 12'($random(seed));
        iu  = 20'($random(seed));
        r5  = sext12(ia);
        r6  = r5 + sext12(ib);
        r7  = r6 + r5;
        r9  = {iu, 12'b0};
        r8  = r7 - r9;
        r10 = {31'b0, r8 < r7};
        clear_memory();
        emit(addi_word(5'd5, 5'd0, ia));
        emit(addi_word(5'd6, 5'd5, ib));
        emit(rtype_word(7'h00, 3'b000, 5'd7, 5'd6, 5'd5));
        emit(lui_word(5'd9, iu));
        emit(rtype_word(f7_sub, 3'b000, 5'd8, 5'd7, 5'd9));
        emit(rtype_word(7'h00, 3'b011, 5'd10, 5'd8, 5'd7));
        emit(rtype_word(7'h00, 3'b000, 5'd3, 5'd8, 5'd10));
        emit(ecall_word());
        run_program("arith_chain");
        check_value("arith_chain", r8 + r10, gp);
    endtask

    task automatic multiply();
        logic [19:0] h1;
        logic [19:0] h2;
        logic [11:0] l1;
        logic [11:0] l2;
        logic [31:0] a;
        logic [31:0] b;
        h1 = 20'($random(seed));
        h2 = 20'($random(seed));
        l1 = 12'($random(seed));
        l2 = 12'($random(seed));
        a  = {h1, 12'b0} + sext12(l1);
        b  = {h2, 12'b0} + sext12(l2);
        clear_memory();
        emit(lui_word(5'd5, h1));
        emit(addi_word(5'd5, 5'd5, l1));
        emit(lui_word(5'd6, h2));
        emit(addi_word(5'd6, 5'd6, l2));
        emit(rtype_word(f7_mul, 3'b000, 5'd7, 5'd5, 5'd6));
        // dependent add waits on the multiplier
        emit(rtype_word(7'h00, 3'b000, 5'd3, 5'd7, 5'd0));
        emit(ecall_word());
        run_program("multiply");
        check_value("multiply", a * b, gp);
    endtask

    task automatic control_flow();
        clear_memory();
        emit(addi_word(5'd3, 5'd0, 12'd5));
        emit(addi_word(5'd5, 5'd0, 12'd7));
        emit(branch_word(3'b000, 5'd5, 5'd5, 13'd12));
        emit(addi_word(5'd3, 5'd0, 12'd99));
        emit(addi_word(5'd3, 5'd0, 12'd98));
        emit(branch_word(3'b001, 5'd5, 5'd5, 13'd8));
        emit(addi_word(5'd3, 5'd3, 12'd1));
        emit(jal_word(5'd6, 21'd12));
        emit(addi_word(5'd3, 5'd0, 12'd97));
        emit(addi_word(5'd3, 5'd0, 12'd96));
        emit(rtype_word(7'h00, 3'b000, 5'd3, 5'd3, 5'd6));
        emit(ecall_word());
        exp_targets.push_back(32'd20);
        exp_targets.push_back(32'd40);
        run_program("control_flow");
        // 5, plus one from the fall-through, plus the link 32
        check_value("control_flow", 32'd5 + 32'd1 + 32'd32, gp);
        check_value("control_flow redirects left", 32'd0, exp_targets.size());
    endtask

    task automatic counter_reads();
        clear_memory();
        for (int k = 0; k < 6; k++) begin
            emit(addi_word(5'(5 + k), 5'd0, 12'(k + 1)));
        end
        emit(csrr_word(5'd3, csr_instret_addr_tb));
        emit(ecall_word());
        run_program("instret_read");
        check_value("instret_read", 32'd6, gp);
        clear_memory();
        emit(csrr_word(5'd5, csr_cycle_addr));
        emit(csrr_word(5'd6, csr_cycle_addr));
        emit(rtype_word(7'h00, 3'b011, 5'd3, 5'd5, 5'd6));
        emit(ecall_word());
        run_program("cycle_read");
        check_value("cycle_read", 32'd1, gp);
    endtask

    task automatic reset_and_halt();
        clear_memory();
        emit(addi_word(5'd3, 5'd0, 12'h2a5));
        emit(ecall_word());
        run_program("reset_and_halt");
        check_value("reset_and_halt", sext12(12'h2a5), gp);
        repeat (20) begin
            @(negedge clk);
            check_value("reset_and_halt exit held", 32'd1, exit);
            check_value("reset_and_halt fetch_ready", 32'd0, fetch_ready);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        iresp     = '0;
        nxt_pc    = '0;
        nxt_valid = 1'b0;
        seed      = 32'he2ff;
        clear_memory();
        arith_chain();
        multiply();
        control_flow();
        counter_reads();
        reset_and_halt();
        if (i_dut.i_props.fail_count != 0) begin
            $display("a bound assertion on the core pipeline failed");
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* flist.f */
verilog/core_pkg.sv
verilog/mul_unit.sv
verilog/perf_counters.sv
verilog/writeback_regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/core.sv
dv/core_properties.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: rv32_core

sources:
  - verilog/core_pkg.sv
  - verilog/mul_unit.sv
  - verilog/perf_counters.sv
  - verilog/writeback_regfile.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/core.sv
  - target: test
    files:
      - dv/core_properties.sv
      - dv/core_tb.sv
